// ==== design/trade_pkg.sv ====
package trade_pkg;

    // code 0 is the index check action, which is reserved here
    typedef enum logic [1:0] {
        act_update     = 2'd1,
        act_check_date = 2'd2
    } action_t;

    // code 2 belongs to the dropped risk warning
    typedef enum logic [1:0] {
        no_warn   = 2'd0,
        date_warn = 2'd1,
        data_warn = 2'd3
    } warn_t;

    typedef logic [3:0] month_t;
    typedef logic [4:0] day_t;

    typedef struct packed {
        month_t month;
        day_t   day;
    } date_t;

    typedef logic [7:0]         data_no_t;
    typedef logic [11:0]        index_t;
    typedef logic signed [11:0] delta_t;
    typedef logic [16:0]        dram_addr_t;

    // DRAM record layout, msb first
    typedef struct packed {
        index_t     idx_a;
        index_t     idx_b;
        logic [3:0] month_pad;
        month_t     month;
        index_t     idx_c;
        index_t     idx_d;
        logic [2:0] day_pad;
        day_t       day;
    } stock_rec_t;

    localparam int REC_BYTES = 8;
    localparam int INDEX_MAX = 4095;
    localparam int NUM_INDEX = 4;
    localparam int IN_W      = 12;

endpackage

// ==== design/dram_link_if.sv ====
`timescale 1ns/1ps

// one record request between the controller and the DRAM master over a four-phase req/ack
interface dram_link_if;
    import trade_pkg::*;

    logic       req;
    logic       write;
    data_no_t   data_no;
    stock_rec_t wdata;
    // valid while ack is high
    stock_rec_t rdata;
    logic       ack;

    modport ctrl (output req, write, data_no, wdata, input rdata, ack);
    modport mem (input req, write, data_no, wdata, output rdata, ack);

endinterface

// ==== design/cmd_capture.sv ====
`timescale 1ns/1ps

module cmd_capture (
    input  logic                        clk,
    input  logic                        inf,
    input  logic                        sel_action_valid,
    input  logic                        date_valid,
    input  logic                        data_no_valid,
    input  logic                        index_valid,
    input  logic [trade_pkg::IN_W-1:0]  in_data,
    output trade_pkg::action_t          act,
    output trade_pkg::date_t            date,
    output trade_pkg::data_no_t         data_no,
    output trade_pkg::delta_t           deltas [trade_pkg::NUM_INDEX],
    output logic                        idx_done
);
    import trade_pkg::*;

    localparam int CNT_W = $clog2(NUM_INDEX + 1);

    logic [CNT_W-1:0] idx_cnt;

    // saturates at four until the next action starts
    assign idx_done = (idx_cnt == CNT_W'(NUM_INDEX));

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            idx_cnt <= '0;
        end
        else if (sel_action_valid) begin
            idx_cnt <= '0;
        end
        else if (index_valid && !idx_done) begin
            idx_cnt <= idx_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_action_valid) begin
            act <= action_t'(in_data[1:0]);
        end
        if (date_valid) begin
            date <= date_t'(in_data[$bits(date_t)-1:0]);
        end
        if (data_no_valid) begin
            data_no <= in_data[$bits(data_no_t)-1:0];
        end
        // first index ends up in slot 0 after four arrivals
        if (index_valid) begin
            for (int i = 0; i < NUM_INDEX - 1; i++) begin
                deltas[i] <= deltas[i+1];
            end
            deltas[NUM_INDEX-1] <= delta_t'(in_data);
        end
    end

endmodule

// ==== design/dram_master.sv ====
`timescale 1ns/1ps

module dram_master #(
    parameter trade_pkg::dram_addr_t DRAM_BASE = 17'h10000
) (
    input  logic                    clk,
    input  logic                    inf,
    dram_link_if.mem                link,
    output logic                    ar_valid,
    output trade_pkg::dram_addr_t   ar_addr,
    input  logic                    ar_ready,
    input  logic                    r_valid,
    input  trade_pkg::stock_rec_t   r_data,
    output logic                    r_ready,
    output logic                    aw_valid,
    output trade_pkg::dram_addr_t   aw_addr,
    input  logic                    aw_ready,
    output logic                    w_valid,
    output trade_pkg::stock_rec_t   w_data,
    input  logic                    w_ready,
    input  logic                    b_valid,
    output logic                    b_ready
);
    import trade_pkg::*;

    typedef enum logic [2:0] {m_idle, m_ar, m_r, m_aw, m_w, m_b, m_ack} mstate_t;

    mstate_t    state;
    dram_addr_t rec_addr;

    assign rec_addr = dram_addr_t'(DRAM_BASE + link.data_no * REC_BYTES);

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state     <= m_idle;
            ar_valid  <= 1'b0;
            r_ready   <= 1'b0;
            aw_valid  <= 1'b0;
            w_valid   <= 1'b0;
            b_ready   <= 1'b0;
            link.ack  <= 1'b0;
        end
        else begin
            case (state)
                m_idle: begin
                    if (link.req && link.write) begin
                        aw_valid <= 1'b1;
                        state    <= m_aw;
                    end
                    else if (link.req) begin
                        ar_valid <= 1'b1;
                        state    <= m_ar;
                    end
                end
                m_ar: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                        state    <= m_r;
                    end
                end
                m_r: begin
                    if (r_valid) begin
                        r_ready  <= 1'b0;
                        link.ack <= 1'b1;
                        state    <= m_ack;
                    end
                end
                m_aw: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                        w_valid  <= 1'b1;
                        state    <= m_w;
                    end
                end
                m_w: begin
                    if (w_ready) begin
                        w_valid <= 1'b0;
                        b_ready <= 1'b1;
                        state   <= m_b;
                    end
                end
                m_b: begin
                    if (b_valid) begin
                        b_ready  <= 1'b0;
                        link.ack <= 1'b1;
                        state    <= m_ack;
                    end
                end
                // hold ack until the controller lets go of req
                m_ack: begin
                    if (!link.req) begin
                        link.ack <= 1'b0;
                        state    <= m_idle;
                    end
                end
                default: state <= m_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == m_idle && link.req) begin
            ar_addr <= rec_addr;
            aw_addr <= rec_addr;
            w_data  <= link.wdata;
        end
        if (state == m_r && r_valid) begin
            link.rdata <= r_data;
        end
    end

endmodule

// ==== design/index_update.sv ====
`timescale 1ns/1ps

module index_update (
    input  logic                    clk,
    input  logic                    inf,
    input  logic                    start,
    input  trade_pkg::stock_rec_t   rec_in,
    input  trade_pkg::delta_t       deltas [trade_pkg::NUM_INDEX],
    input  trade_pkg::date_t        new_date,
    output trade_pkg::stock_rec_t   rec_out,
    output logic                    clamped,
    output logic                    upd_valid
);
    import trade_pkg::*;

    index_t               cur_idx [NUM_INDEX];
    logic signed [13:0]   s1_sum [NUM_INDEX];
    date_t                s1_date;
    logic                 s1_valid;
    index_t               clip [NUM_INDEX];
    logic [NUM_INDEX-1:0] clip_flag;
    stock_rec_t           packed_rec;

    // same order as the deltas arrive
    assign cur_idx[0] = rec_in.idx_a;
    assign cur_idx[1] = rec_in.idx_b;
    assign cur_idx[2] = rec_in.idx_c;
    assign cur_idx[3] = rec_in.idx_d;

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            s1_valid  <= 1'b0;
            upd_valid <= 1'b0;
        end
        else begin
            s1_valid  <= start;
            upd_valid <= s1_valid;
        end
    end

    // stage one sums are wide enough for 4095 + 2047 and 0 - 2048
    always_ff @(posedge clk) begin
        if (start) begin
            for (int i = 0; i < NUM_INDEX; i++) begin
                s1_sum[i] <= $signed({1'b0, cur_idx[i]}) + deltas[i];
            end
            s1_date <= new_date;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_INDEX; i++) begin
            clip_flag[i] = 1'b1;
            if (s1_sum[i] > INDEX_MAX) begin
                clip[i] = index_t'(INDEX_MAX);
            end
            else if (s1_sum[i] < 0) begin
                clip[i] = '0;
            end
            else begin
                clip[i]      = s1_sum[i][11:0];
                clip_flag[i] = 1'b0;
            end
        end
        // pad bits stay zero
        packed_rec       = '0;
        packed_rec.idx_a = clip[0];
        packed_rec.idx_b = clip[1];
        packed_rec.idx_c = clip[2];
        packed_rec.idx_d = clip[3];
        packed_rec.month = s1_date.month;
        packed_rec.day   = s1_date.day;
    end

    // stage two holds its result until the next update
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            rec_out <= packed_rec;
            clamped <= |clip_flag;
        end
    end

endmodule

// ==== design/trade_ctrl.sv ====
`timescale 1ns/1ps

module trade_ctrl (
    input  logic                    clk,
    input  logic                    inf,
    input  logic                    sel_action_valid,
    input  trade_pkg::action_t      act,
    input  logic                    data_no_valid,
    input  logic                    idx_done,
    input  trade_pkg::date_t        date,
    input  trade_pkg::data_no_t     data_no,
    dram_link_if.ctrl               link,
    output logic                    upd_start,
    input  trade_pkg::stock_rec_t   upd_rec,
    input  logic                    clamped,
    input  logic                    upd_valid,
    output trade_pkg::stock_rec_t   upd_src,
    output logic                    out_valid,
    output trade_pkg::warn_t        warn_msg,
    output logic                    complete
);
    import trade_pkg::*;

    typedef enum logic [2:0] {st_idle, st_wait, st_read, st_calc, st_write, st_resp} state_t;

    state_t state;
    state_t state_next;
    logic   is_early;
    logic   clamp_q;
    logic   out_valid_next;
    warn_t  warn_next;
    logic   complete_next;

    // trading date before the stored one
    assign is_early = (date.month < link.rdata.month) ||
                      (date.month == link.rdata.month && date.day < link.rdata.day);

    assign link.req     = (state == st_read) || (state == st_write);
    assign link.write   = (state == st_write);
    assign link.data_no = data_no;
    assign link.wdata   = upd_rec;

    always_comb begin
        state_next     = state;
        out_valid_next = 1'b0;
        warn_next      = no_warn;
        complete_next  = 1'b0;
        case (state)
            st_idle: begin
                if (sel_action_valid) begin
                    state_next = st_wait;
                end
            end
            // reserved action codes fall back to idle
            st_wait: begin
                if (act == act_check_date) begin
                    state_next = data_no_valid ? st_read : st_wait;
                end
                else if (act == act_update) begin
                    state_next = idx_done ? st_read : st_wait;
                end
                else begin
                    state_next = st_idle;
                end
            end
            st_read: begin
                if (link.ack && act == act_update) begin
                    state_next = st_calc;
                end
                else if (link.ack) begin
                    state_next     = st_resp;
                    out_valid_next = 1'b1;
                    warn_next      = is_early ? date_warn : no_warn;
                    complete_next  = !is_early;
                end
            end
            st_calc: begin
                if (upd_valid) begin
                    state_next = st_write;
                end
            end
            st_write: begin
                if (link.ack) begin
                    state_next     = st_resp;
                    out_valid_next = 1'b1;
                    warn_next      = clamp_q ? data_warn : no_warn;
                    complete_next  = !clamp_q;
                end
            end
            // a new action may start here while ack is still falling
            st_resp: begin
                if (sel_action_valid) begin
                    state_next = st_wait;
                end
                else if (!link.ack) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state     <= st_idle;
            out_valid <= 1'b0;
            warn_msg  <= no_warn;
            complete  <= 1'b0;
            upd_start <= 1'b0;
            clamp_q   <= 1'b0;
        end
        else begin
            state     <= state_next;
            out_valid <= out_valid_next;
            warn_msg  <= warn_next;
            complete  <= complete_next;
            upd_start <= (state == st_read) && link.ack && (act == act_update);
            if (state == st_calc && upd_valid) begin
                clamp_q <= clamped;
            end
        end
    end

    // stored record for the update pipeline
    always_ff @(posedge clk) begin
        if (state == st_read && link.ack) begin
            upd_src <= link.rdata;
        end
    end

endmodule

// ==== design/trade_top.sv ====
`timescale 1ns/1ps

module trade_top #(
    parameter trade_pkg::dram_addr_t DRAM_BASE = 17'h10000
) (
    input  logic                        clk,
    input  logic                        inf,
    input  logic                        sel_action_valid,
    input  logic                        date_valid,
    input  logic                        data_no_valid,
    input  logic                        index_valid,
    input  logic [trade_pkg::IN_W-1:0]  in_data,
    output logic                        out_valid,
    output trade_pkg::warn_t            warn_msg,
    output logic                        complete,
    output logic                        ar_valid,
    output trade_pkg::dram_addr_t       ar_addr,
    input  logic                        ar_ready,
    input  logic                        r_valid,
    input  trade_pkg::stock_rec_t       r_data,
    output logic                        r_ready,
    output logic                        aw_valid,
    output trade_pkg::dram_addr_t       aw_addr,
    input  logic                        aw_ready,
    output logic                        w_valid,
    output trade_pkg::stock_rec_t       w_data,
    input  logic                        w_ready,
    input  logic                        b_valid,
    output logic                        b_ready
);
    import trade_pkg::*;

    action_t    act;
    date_t      date;
    data_no_t   data_no;
    delta_t     deltas [NUM_INDEX];
    logic       idx_done;
    logic       upd_start;
    stock_rec_t upd_src;
    stock_rec_t upd_rec;
    logic       clamped;
    logic       upd_valid;

    dram_link_if link ();

    cmd_capture i_capture (
        .clk(clk), .inf(inf),
        .sel_action_valid(sel_action_valid), .date_valid(date_valid),
        .data_no_valid(data_no_valid), .index_valid(index_valid), .in_data(in_data),
        .act(act), .date(date), .data_no(data_no), .deltas(deltas), .idx_done(idx_done)
    );

    trade_ctrl i_ctrl (
        .clk(clk), .inf(inf),
        .sel_action_valid(sel_action_valid), .act(act), .data_no_valid(data_no_valid),
        .idx_done(idx_done), .date(date), .data_no(data_no), .link(link.ctrl),
        .upd_start(upd_start), .upd_rec(upd_rec), .clamped(clamped), .upd_valid(upd_valid),
        .upd_src(upd_src), .out_valid(out_valid), .warn_msg(warn_msg), .complete(complete)
    );

    index_update i_update (
        .clk(clk), .inf(inf), .start(upd_start), .rec_in(upd_src), .deltas(deltas),
        .new_date(date), .rec_out(upd_rec), .clamped(clamped), .upd_valid(upd_valid)
    );

    dram_master #(.DRAM_BASE(DRAM_BASE)) i_dram (
        .clk(clk), .inf(inf), .link(link.mem),
        .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
        .r_valid(r_valid), .r_data(r_data), .r_ready(r_ready),
        .aw_valid(aw_valid), .aw_addr(aw_addr), .aw_ready(aw_ready),
        .w_valid(w_valid), .w_data(w_data), .w_ready(w_ready),
        .b_valid(b_valid), .b_ready(b_ready)
    );

endmodule

// ==== dv/trade_props.sv ====
`timescale 1ns/1ps

module trade_props (
    input logic                  clk,
    input logic                  inf,
    input logic                  out_valid,
    input trade_pkg::warn_t      warn_msg,
    input logic                  complete,
    input logic                  ar_valid,
    input trade_pkg::dram_addr_t ar_addr,
    input logic                  ar_ready,
    input logic                  aw_valid,
    input trade_pkg::dram_addr_t aw_addr,
    input logic                  aw_ready,
    input logic                  w_valid,
    input trade_pkg::stock_rec_t w_data,
    input logic                  w_ready
);
    import trade_pkg::*;

    a_out_pulse: assert property (@(posedge clk) disable iff (!inf)
        out_valid |=> !out_valid)
        else $error("out_valid stayed high for more than one cycle");

    a_complete_clean: assert property (@(posedge clk) disable iff (!inf)
        complete |-> warn_msg == no_warn)
        else $error("complete raised together with a warning");

    // valid and its fields hold until ready
    a_ar_hold: assert property (@(posedge clk) disable iff (!inf)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("read address channel changed before ar_ready");

    a_aw_hold: assert property (@(posedge clk) disable iff (!inf)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else $error("write address channel changed before aw_ready");

    a_w_hold: assert property (@(posedge clk) disable iff (!inf)
        w_valid && !w_ready |=> w_valid && $stable(w_data))
        else $error("write data channel changed before w_ready");

endmodule

bind trade_top trade_props i_props (
    .clk(clk), .inf(inf), .out_valid(out_valid), .warn_msg(warn_msg), .complete(complete),
    .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
    .aw_valid(aw_valid), .aw_addr(aw_addr), .aw_ready(aw_ready),
    .w_valid(w_valid), .w_data(w_data), .w_ready(w_ready)
);

// ==== dv/tb_trade.sv ====
`timescale 1ns/1ps

module tb_trade;
    import trade_pkg::*;

    localparam dram_addr_t  DRAM_BASE       = 17'h0a000;
    localparam logic [15:0] LFSR_SEED       = 16'd3843;
    localparam int          CYCLES_PER_TEST = 60;
    localparam int          PULSE_ACTION    = 0;
    localparam int          PULSE_DATE      = 1;
    localparam int          PULSE_DATA_NO   = 2;
    localparam int          PULSE_INDEX     = 3;

    logic            clk;
    logic            inf;
    logic            sel_action_valid;
    logic            date_valid;
    logic            data_no_valid;
    logic            index_valid;
    logic [IN_W-1:0] in_data;
    logic            out_valid;
    warn_t           warn_msg;
    logic            complete;
    logic            ar_valid;
    dram_addr_t      ar_addr;
    logic            ar_ready;
    logic            r_valid;
    stock_rec_t      r_data;
    logic            r_ready;
    logic            aw_valid;
    dram_addr_t      aw_addr;
    logic            aw_ready;
    logic            w_valid;
    stock_rec_t      w_data;
    logic            w_ready;
    logic            b_valid;
    logic            b_ready;

    // DRAM model keyed by byte address
    stock_rec_t  mem [dram_addr_t];
    dram_addr_t  exp_addr;
    int          write_count;
    int          cycle_limit;
    logic [15:0] dram_lfsr;
    logic [15:0] gap_lfsr;

    trade_top #(.DRAM_BASE(DRAM_BASE)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic end_with_failure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_warn(input string name, input warn_t got, input warn_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("[ERROR] %0t %s: got %0d expected %0d",
                                       $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            end_with_failure($sformatf("[ERROR] %0t %s: got %b expected %b",
                                       $time, name, got, exp));
        end
    endtask

    task automatic check_rec(input string name, input stock_rec_t got, input stock_rec_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("[ERROR] %0t %s: got %h expected %h",
                                       $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input dram_addr_t got, input dram_addr_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("[ERROR] %0t %s: got %h expected %h",
                                       $time, name, got, exp));
        end
    endtask

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(inout logic [15:0] s, input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            s   = lfsr_next(s);
            val = (val << 1) | int'(s[0]);
        end
    endtask

    task automatic dram_delay();
        int n;
        take_bits(dram_lfsr, 2, n);
        repeat (n) @(negedge clk);
    endtask

    task automatic idle_gap();
        int n;
        take_bits(gap_lfsr, 2, n);
        repeat (n) @(negedge clk);
    endtask

    task automatic serve_read();
        dram_addr_t addr;
        addr = ar_addr;
        check_addr("ar_addr", addr, exp_addr);
        dram_delay();
        ar_ready = 1'b1;
        @(negedge clk);
        ar_ready = 1'b0;
        while (!r_ready) @(negedge clk);
        dram_delay();
        if (!mem.exists(addr)) begin
            end_with_failure("DRAM read from an address that holds no record");
        end
        r_valid = 1'b1;
        r_data  = mem[addr];
        @(negedge clk);
        r_valid = 1'b0;
    endtask

    task automatic serve_write();
        dram_addr_t addr;
        stock_rec_t data;
        addr = aw_addr;
        check_addr("aw_addr", addr, exp_addr);
        dram_delay();
        aw_ready = 1'b1;
        @(negedge clk);
        aw_ready = 1'b0;
        while (!w_valid) @(negedge clk);
        dram_delay();
        w_ready = 1'b1;
        data    = w_data;
        @(negedge clk);
        w_ready = 1'b0;
        mem[addr] = data;
        write_count++;
        while (!b_ready) @(negedge clk);
        dram_delay();
        b_valid = 1'b1;
        @(negedge clk);
        b_valid = 1'b0;
    endtask

    // answers one channel at a time after 0 to 3 cycles
    initial begin : dram_responder
        dram_lfsr = LFSR_SEED;
        ar_ready  = 1'b0;
        r_valid   = 1'b0;
        r_data    = '0;
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        b_valid   = 1'b0;
        forever begin
            @(negedge clk);
            if (inf && ar_valid) begin
                serve_read();
            end
            else if (inf && aw_valid) begin
                serve_write();
            end
        end
    end

    task automatic pulse_input(input int kind, input logic [IN_W-1:0] value);
        in_data = value;
        case (kind)
            PULSE_ACTION:  sel_action_valid = 1'b1;
            PULSE_DATE:    date_valid = 1'b1;
            PULSE_DATA_NO: data_no_valid = 1'b1;
            default:       index_valid = 1'b1;
        endcase
        @(negedge clk);
        sel_action_valid = 1'b0;
        date_valid       = 1'b0;
        data_no_valid    = 1'b0;
        index_valid      = 1'b0;
        in_data          = '0;
    endtask

    task automatic check_reset_state();
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("complete", complete, 1'b0);
        check_warn("warn_msg", warn_msg, no_warn);
        check_bit("ar_valid", ar_valid, 1'b0);
        check_bit("r_ready", r_ready, 1'b0);
        check_bit("aw_valid", aw_valid, 1'b0);
        check_bit("w_valid", w_valid, 1'b0);
        check_bit("b_ready", b_ready, 1'b0);
    endtask

    task automatic run_test(input string line);
        int          n_fields;
        int          act_code;
        int          rec_no;
        int          month;
        int          day;
        int          d [NUM_INDEX];
        int          warn_code;
        int          done_flag;
        logic [63:0] init_rec;
        logic [63:0] exp_rec;
        logic        is_update;
        date_t       in_date;
        n_fields = $sscanf(line, "%d %d %d %d %d %d %d %d %h %d %d %h",
                           act_code, rec_no, month, day, d[0], d[1], d[2], d[3],
                           init_rec, warn_code, done_flag, exp_rec);
        if (n_fields != 12) begin
            end_with_failure({"malformed stimulus line: ", line});
        end
        if (act_code != int'(act_update) && act_code != int'(act_check_date)) begin
            end_with_failure({"unknown action code in stimulus line: ", line});
        end
        is_update = (act_code == int'(act_update));
        exp_addr  = dram_addr_t'(DRAM_BASE + REC_BYTES * rec_no);
        mem[exp_addr] = stock_rec_t'(init_rec);
        write_count   = 0;

        // the action goes out right after the previous result
        pulse_input(PULSE_ACTION, IN_W'(act_code));
        idle_gap();
        in_date.month = month_t'(month);
        in_date.day   = day_t'(day);
        pulse_input(PULSE_DATE, IN_W'(in_date));
        idle_gap();
        pulse_input(PULSE_DATA_NO, IN_W'(rec_no));
        if (is_update) begin
            for (int i = 0; i < NUM_INDEX; i++) begin
                idle_gap();
                pulse_input(PULSE_INDEX, IN_W'(d[i]));
            end
        end

        while (!out_valid) @(negedge clk);
        check_warn("warn_msg", warn_msg, warn_t'(warn_code));
        check_bit("complete", complete, logic'(done_flag != 0));
        check_bit("dram write", logic'(write_count != 0), is_update);
        check_rec("dram record", mem[exp_addr], stock_rec_t'(exp_rec));
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycle_limit > 0 && cycles > cycle_limit) begin
                end_with_failure($sformatf("timeout: no result after %0d clock cycles", cycles));
            end
        end
    end

    initial begin : stimulus
        int    fd;
        string line;
        string lines [$];
        inf              = 1'b0;
        sel_action_valid = 1'b0;
        date_valid       = 1'b0;
        data_no_valid    = 1'b0;
        index_valid      = 1'b0;
        in_data          = '0;
        gap_lfsr         = LFSR_SEED;
        exp_addr         = '0;
        write_count      = 0;
        cycle_limit      = 0;

        fd = $fopen("dv/trade_stimulus.txt", "r");
        if (fd == 0) begin
            end_with_failure("cannot open dv/trade_stimulus.txt");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        if (lines.size() == 0) begin
            end_with_failure("the stimulus file holds no tests");
        end
        cycle_limit = lines.size() * CYCLES_PER_TEST + 100;

        repeat (3) @(posedge clk);
        @(negedge clk);
        inf = 1'b1;
        check_reset_state();
        foreach (lines[i]) begin
            run_test(lines[i]);
        end
        repeat (4) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== dv/trade_stimulus.txt ====
# action(1 update, 2 check) data_no month day delta_a delta_b delta_c delta_d
# initial_record expected_warn(0 none, 1 date, 3 data) expected_complete expected_record
2 3 5 20 0 0 0 0 100200063004000f 1 0 100200063004000f
2 3 6 15 0 0 0 0 100200063004000f 0 1 100200063004000f
2 3 6 14 0 0 0 0 100200063004000f 1 0 100200063004000f
2 3 7 1 0 0 0 0 100200063004000f 0 1 100200063004000f
2 3 6 16 0 0 0 0 100200063004000f 0 1 100200063004000f
2 200 9 28 0 0 0 0 7d005aa9fff000fc 0 1 7d005aa9fff000fc
2 200 12 1 0 0 0 0 7d005aa9fff000fc 0 1 7d005aa9fff000fc
2 200 2 30 0 0 0 0 7d005aa9fff000fc 1 0 7d005aa9fff000fc
1 3 8 10 10 -12 100 -1000 100200063004000f 0 1 10a1f4083640180a
1 3 8 11 -266 2047 0 2047 10a1f4083640180a 0 1 0009f3083648170b
2 3 8 11 0 0 0 0 0009f3083648170b 0 1 0009f3083648170b
1 200 10 5 1000 -91 1 -1 7d005aa9fff000fc 3 0 bb80000afff00005
2 200 10 4 0 0 0 0 bb80000afff00005 1 0 bb80000afff00005
1 200 11 30 1095 2047 -2048 2047 bb80000afff00005 0 1 fff7ff0b7ff7ff1e
1 0 3 1 -2 -2048 5 7 001002e3003004a1 3 0 0000000300800b01
2 255 8 31 0 0 0 0 fedcba98765432ff 0 1 fedcba98765432ff
2 255 8 30 0 0 0 0 fedcba98765432ff 1 0 fedcba98765432ff

// ==== trade.f ====
design/trade_pkg.sv
design/dram_link_if.sv
design/cmd_capture.sv
design/dram_master.sv
design/index_update.sv
design/trade_ctrl.sv
design/trade_top.sv
dv/trade_props.sv
dv/tb_trade.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_trade -f trade.f -o tb_trade &&
./obj_dir/tb_trade ||
exit 1
